//--- src.f
+incdir+verification
verilog/ising_pkg.sv
verilog/weight_cell.sv
verilog/recursive_matrix.sv
verilog/host_port.sv
verilog/sweep_engine.sv
verilog/ising_top.sv
verification/ising_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f src.f --top-module ising_tb -o ising_sim \
    && ./obj_dir/ising_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
exit 0

//--- verification/ising_ref.svh
// --------------------------------------------------------------------------
// Reference model of the annealer, included in the testbench module body
// --------------------------------------------------------------------------
`ifndef ISING_REF_SVH
`define ISING_REF_SVH

// Symmetric weights, the diagonal stays zero
int              ref_w [TB_N][TB_N];
logic [TB_N-1:0] ref_spins;

function automatic void ref_clear();
    for (int r = 0; r < TB_N; r++) begin
        for (int c = 0; c < TB_N; c++) begin
            ref_w[r][c] = 0;
        end
    end
    ref_spins = '0;
endfunction

// A pair and its mirror always hold the same weight
function automatic void ref_write(input int r, input int c, input logic [DATA_W-1:0] data);
    logic signed [TB_W-1:0] weight;
    weight = data[TB_W-1:0];
    if (r != c) begin
        ref_w[r][c] = int'(weight);
        ref_w[c][r] = int'(weight);
    end
endfunction

function automatic logic [DATA_W-1:0] ref_read(input int r, input int c);
    return ref_w[r][c];
endfunction

// Each spin in turn follows the sign of its local field
function automatic void ref_sweep(input int count);
    int field;
    for (int s = 0; s < count; s++) begin
        for (int i = 0; i < TB_N; i++) begin
            field = 0;
            for (int j = 0; j < TB_N; j++) begin
                if (j != i) begin
                    field += ref_spins[j] ? ref_w[i][j] : -ref_w[i][j];
                end
            end
            if (field > 0) begin
                ref_spins[i] = 1'b1;
            end else if (field < 0) begin
                ref_spins[i] = 1'b0;
            end
        end
    end
endfunction

`endif

//--- verification/ising_tb.sv
// --------------------------------------------------------------------------
// Testbench for the annealer, drives host commands and checks against a model
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ising_tb;

    import ising_pkg::*;

    localparam int TB_N    = 8;
    localparam int TB_W    = 5;
    localparam int LOG_N   = $clog2(TB_N);
    localparam int TIMEOUT = 2000;

    logic              clk;
    logic              reset;
    logic              req;
    cmd_e              cmd;
    logic [LOG_N-1:0]  row;
    logic [LOG_N-1:0]  col;
    logic [DATA_W-1:0] wdata;
    logic              ack;
    logic [DATA_W-1:0] rdata;
    logic [TB_N-1:0]   spins;
    logic              busy;

    int                errors;
    int                checks;
    logic              timed_out;
    logic              ack_seen;
    logic              exp_check_rdata;
    logic [DATA_W-1:0] exp_rdata;
    logic [TB_N-1:0]   exp_spins;

    `include "ising_ref.svh"

    ising_top #(.N(TB_N), .W(TB_W)) DUT (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .cmd   (cmd),
        .row   (row),
        .col   (col),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata),
        .spins (spins),
        .busy  (busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Outputs are compared on the first falling edge with ack high
    always @(negedge clk) begin
        if (ack && !ack_seen) begin
            checks = checks + 1;
            if (exp_check_rdata && rdata !== exp_rdata) begin
                errors = errors + 1;
                $display("[ERROR] %0t: rdata %h, expected %h", $time, rdata, exp_rdata);
            end
            if (spins !== exp_spins) begin
                errors = errors + 1;
                $display("[ERROR] %0t: spins %b, expected %b", $time, spins, exp_spins);
            end
        end
        ack_seen = ack;
    end

    task automatic wait_ack_low();
        int waited;
        waited = 0;
        while (ack && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (ack) begin
            errors    = errors + 1;
            timed_out = 1'b1;
            $display("Timed out at %0t waiting for ack to fall", $time);
        end
    endtask

    // One four-phase transaction, fixed commands answer in 2 cycles
    task automatic host_access(input cmd_e op, input int r, input int c,
                               input logic [DATA_W-1:0] data, input logic check_latency);
        int waited;
        if (!timed_out) begin
            cmd    = op;
            row    = r[LOG_N-1:0];
            col    = c[LOG_N-1:0];
            wdata  = data;
            req    = 1'b1;
            waited = 0;
            while (!ack && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!ack) begin
                errors    = errors + 1;
                timed_out = 1'b1;
                $display("Timed out at %0t waiting for ack to rise", $time);
            end else begin
                if (check_latency && waited != 3) begin
                    errors = errors + 1;
                    $display("[ERROR] %0t: ack took %0d cycles, expected 2 after req",
                             $time, waited - 1);
                end
                req = 1'b0;
                wait_ack_low();
            end
        end
    endtask

    task automatic write_weight(input int r, input int c, input logic [DATA_W-1:0] data);
        ref_write(r, c, data);
        exp_check_rdata = 1'b0;
        exp_spins       = ref_spins;
        host_access(CMD_WRITE_WEIGHT, r, c, data, 1'b1);
    endtask

    task automatic read_weight(input int r, input int c);
        exp_check_rdata = 1'b1;
        exp_rdata       = ref_read(r, c);
        exp_spins       = ref_spins;
        host_access(CMD_READ_WEIGHT, r, c, $urandom(), 1'b1);
    endtask

    task automatic read_all_pairs();
        for (int r = 0; r < TB_N; r++) begin
            for (int c = r; c < TB_N; c++) begin
                read_weight(r, c);
            end
        end
    endtask

    task automatic load_state(input logic [DATA_W-1:0] data);
        ref_spins       = data[TB_N-1:0];
        exp_check_rdata = 1'b1;
        exp_rdata       = {{(DATA_W - TB_N){1'b0}}, ref_spins};
        exp_spins       = ref_spins;
        host_access(CMD_LOAD_SPINS, 0, 0, data, 1'b1);
    endtask

    task automatic run_sweeps(input int count);
        ref_sweep(count);
        exp_check_rdata = 1'b1;
        exp_rdata       = {{(DATA_W - TB_N){1'b0}}, ref_spins};
        exp_spins       = ref_spins;
        host_access(CMD_RUN, 0, 0, count, count == 0);
    endtask

    // A load presented while busy must wait until the run's ack has fallen
    task automatic check_held_request(input int count, input logic [DATA_W-1:0] next);
        int   waited;
        logic busy_seen;
        if (!timed_out) begin
            ref_sweep(count);
            exp_check_rdata = 1'b1;
            exp_rdata       = {{(DATA_W - TB_N){1'b0}}, ref_spins};
            exp_spins       = ref_spins;
            cmd       = CMD_RUN;
            wdata     = count;
            req       = 1'b1;
            waited    = 0;
            busy_seen = 1'b0;
            while (!ack && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
                if (busy && !busy_seen) begin
                    busy_seen = 1'b1;
                    cmd       = CMD_LOAD_SPINS;
                    wdata     = next;
                end
            end
            if (!ack) begin
                errors    = errors + 1;
                timed_out = 1'b1;
                $display("Timed out at %0t waiting for the run to finish", $time);
            end else begin
                if (!busy_seen) begin
                    errors = errors + 1;
                    $display("[ERROR] %0t: busy never rose during the run", $time);
                end
                repeat (4) begin
                    @(negedge clk);
                    if (ack !== 1'b1 || spins !== exp_spins) begin
                        errors = errors + 1;
                        $display("[ERROR] %0t: second command taken before ack fell", $time);
                    end
                end
                req = 1'b0;
                wait_ack_low();
                load_state(next);
            end
        end
    endtask

    initial begin
        int r;
        int c;
        void'($urandom(32'h7032_ef8c));
        errors          = 0;
        checks          = 0;
        timed_out       = 1'b0;
        ack_seen        = 1'b0;
        exp_check_rdata = 1'b0;
        exp_rdata       = '0;
        exp_spins       = '0;
        reset           = 1'b1;
        req             = 1'b0;
        cmd             = CMD_WRITE_WEIGHT;
        row             = '0;
        col             = '0;
        wdata           = '0;
        ref_clear();
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Everything starts cleared
        if (spins !== '0 || busy !== 1'b0) begin
            errors = errors + 1;
            $display("[ERROR] %0t: spins %b busy %b after reset", $time, spins, busy);
        end
        read_all_pairs();

        // Random pairs in either order, read back both ways
        repeat (24) begin
            r = $urandom_range(TB_N - 1);
            c = $urandom_range(TB_N - 1);
            write_weight(r, c, $urandom());
            read_weight(r, c);
            read_weight(c, r);
        end
        read_all_pairs();

        // Self coupling is never stored
        write_weight(3, 3, 32'h0000_000b);
        read_weight(3, 3);

        load_state($urandom());
        run_sweeps(1);
        run_sweeps(0);

        repeat (4) begin
            for (int i = 0; i < TB_N; i++) begin
                for (int j = i + 1; j < TB_N; j++) begin
                    write_weight(i, j, $urandom());
                end
            end
            load_state($urandom());
            run_sweeps($urandom_range(4, 1));
            run_sweeps($urandom_range(4, 1));
        end

        check_held_request(3, $urandom());
        run_sweeps(2);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/ising_top.sv
// --------------------------------------------------------------------------
// Annealer top level, host port plus coupling matrix plus sweep engine
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ising_top #(
    parameter int N = 8,
    parameter int W = 5
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          req,
    input  wire  ising_pkg::cmd_e        cmd,
    input  wire  [$clog2(N)-1:0]         row,
    input  wire  [$clog2(N)-1:0]         col,
    input  wire  [ising_pkg::DATA_W-1:0] wdata,
    output logic                         ack,
    output logic [ising_pkg::DATA_W-1:0] rdata,
    output logic [N-1:0]                 spins,
    output logic                         busy
);

    import ising_pkg::*;

    logic               sel;
    logic               we;
    logic [ADDR_W-1:0]  s_addr;
    logic [ADDR_W-1:0]  d_addr;
    logic [W-1:0]       m_wdata;
    logic [W-1:0]       m_rdata;
    logic               start;
    logic [SWEEP_W-1:0] sweeps;
    logic               load;
    logic [N-1:0]       load_spins;
    logic [ADDR_W-1:0]  eng_s_addr;
    logic [ADDR_W-1:0]  eng_d_addr;

    host_port #(.N(N), .W(W)) u_host (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .cmd        (cmd),
        .row        (row),
        .col        (col),
        .wdata      (wdata),
        .m_rdata    (m_rdata),
        .busy       (busy),
        .spins      (spins),
        .ack        (ack),
        .rdata      (rdata),
        .sel        (sel),
        .we         (we),
        .s_addr     (s_addr),
        .d_addr     (d_addr),
        .m_wdata    (m_wdata),
        .start      (start),
        .sweeps     (sweeps),
        .load       (load),
        .load_spins (load_spins),
        .eng_s_addr (eng_s_addr),
        .eng_d_addr (eng_d_addr)
    );

    recursive_matrix #(.N(N), .W(W), .DIAGONAL(1)) u_matrix (
        .clk    (clk),
        .reset  (reset),
        .sel    (sel),
        .we     (we),
        .s_addr (s_addr),
        .d_addr (d_addr),
        .wdata  (m_wdata),
        .rdata  (m_rdata)
    );

    sweep_engine #(.N(N), .W(W)) u_engine (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .sweeps     (sweeps),
        .load       (load),
        .load_spins (load_spins),
        .m_rdata    (m_rdata),
        .eng_s_addr (eng_s_addr),
        .eng_d_addr (eng_d_addr),
        .busy       (busy),
        .spins      (spins)
    );

endmodule

`default_nettype wire

//--- verilog/sweep_engine.sv
// --------------------------------------------------------------------------
// Sequential sweep engine, one spin at a time follows its local field
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sweep_engine #(
    parameter int N = 8,
    parameter int W = 5
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           start,
    input  wire  [ising_pkg::SWEEP_W-1:0] sweeps,
    input  wire                           load,
    input  wire  [N-1:0]                  load_spins,
    input  wire  [W-1:0]                  m_rdata,
    output logic [ising_pkg::ADDR_W-1:0]  eng_s_addr,
    output logic [ising_pkg::ADDR_W-1:0]  eng_d_addr,
    output logic                          busy,
    output logic [N-1:0]                  spins
);

    import ising_pkg::*;

    localparam int LOG_N = $clog2(N);
    // Room for N-1 terms of up to 2**(W-1) each
    localparam int ACC_W = W + LOG_N + 1;

    logic [LOG_N-1:0]        i_q;
    logic [LOG_N-1:0]        j_q;
    logic [SWEEP_W-1:0]      left_q;
    logic signed [ACC_W-1:0] acc_q;
    logic signed [ACC_W-1:0] weight;
    logic signed [ACC_W-1:0] term;
    logic signed [ACC_W-1:0] sum;
    logic [LOG_N-1:0]        lo_idx;
    logic [LOG_N-1:0]        hi_idx;
    logic                    last_col;
    logic                    last_row;

    // Pair (i, j) is read in upper triangle order
    assign lo_idx     = (i_q < j_q) ? i_q : j_q;
    assign hi_idx     = (i_q < j_q) ? j_q : i_q;
    assign eng_s_addr = {lo_idx, {(ADDR_W - LOG_N){1'b0}}};
    assign eng_d_addr = {hi_idx, {(ADDR_W - LOG_N){1'b0}}};

    assign weight = {{(ACC_W - W){m_rdata[W-1]}}, m_rdata};

    // Spin j up adds the coupling, spin j down subtracts it
    always_comb begin
        if (j_q == i_q) begin
            term = '0;
        end else if (spins[j_q]) begin
            term = weight;
        end else begin
            term = -weight;
        end
    end

    assign sum      = acc_q + term;
    assign last_col = (j_q == N - 1);
    assign last_row = (i_q == N - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy   <= 1'b0;
            spins  <= '0;
            i_q    <= '0;
            j_q    <= '0;
            left_q <= '0;
        end else if (busy) begin
            if (last_col) begin
                // Zero field keeps the spin as it is
                if (sum > 0) begin
                    spins[i_q] <= 1'b1;
                end else if (sum < 0) begin
                    spins[i_q] <= 1'b0;
                end
                j_q <= '0;
                if (last_row) begin
                    i_q    <= '0;
                    left_q <= left_q - 1'b1;
                    if (left_q == 1) begin
                        busy <= 1'b0;
                    end
                end else begin
                    i_q <= i_q + 1'b1;
                end
            end else begin
                j_q <= j_q + 1'b1;
            end
        end else if (start) begin
            busy   <= (sweeps != '0);
            left_q <= sweeps;
            i_q    <= '0;
            j_q    <= '0;
        end else if (load) begin
            spins <= load_spins;
        end
    end

    // Field sum restarts for every spin
    always_ff @(posedge clk) begin
        if (!busy || last_col) begin
            acc_q <= '0;
        end else begin
            acc_q <= sum;
        end
    end

endmodule

`default_nettype wire

//--- verilog/host_port.sv
// --------------------------------------------------------------------------
// Four-phase req/ack command handler, drives matrix access and sweeps
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module host_port #(
    parameter int N = 8,
    parameter int W = 5
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           req,
    input  wire  ising_pkg::cmd_e         cmd,
    input  wire  [$clog2(N)-1:0]          row,
    input  wire  [$clog2(N)-1:0]          col,
    input  wire  [ising_pkg::DATA_W-1:0]  wdata,
    input  wire  [W-1:0]                  m_rdata,
    input  wire                           busy,
    input  wire  [N-1:0]                  spins,
    output logic                          ack,
    output logic [ising_pkg::DATA_W-1:0]  rdata,
    output logic                          sel,
    output logic                          we,
    output logic [ising_pkg::ADDR_W-1:0]  s_addr,
    output logic [ising_pkg::ADDR_W-1:0]  d_addr,
    output logic [W-1:0]                  m_wdata,
    output logic                          start,
    output logic [ising_pkg::SWEEP_W-1:0] sweeps,
    output logic                          load,
    output logic [N-1:0]                  load_spins,
    input  wire  [ising_pkg::ADDR_W-1:0]  eng_s_addr,
    input  wire  [ising_pkg::ADDR_W-1:0]  eng_d_addr
);

    import ising_pkg::*;

    localparam int LOG_N = $clog2(N);

    typedef enum logic [1:0] {ST_IDLE, ST_ACT, ST_ACK, ST_RELEASE} state_e;

    state_e           state_q;
    cmd_e             cmd_q;
    logic             act;
    logic [LOG_N-1:0] lo_idx;
    logic [LOG_N-1:0] hi_idx;

    assign act = (state_q == ST_ACT);

    // Matrix holds the upper triangle only
    assign lo_idx = (row <= col) ? row : col;
    assign hi_idx = (row <= col) ? col : row;

    // Engine owns the address lines while a run is going
    assign s_addr = busy ? eng_s_addr : {lo_idx, {(ADDR_W - LOG_N){1'b0}}};
    assign d_addr = busy ? eng_d_addr : {hi_idx, {(ADDR_W - LOG_N){1'b0}}};

    assign sel        = act && (cmd_q == CMD_WRITE_WEIGHT || cmd_q == CMD_READ_WEIGHT);
    assign we         = act && (cmd_q == CMD_WRITE_WEIGHT);
    assign m_wdata    = wdata[W-1:0];
    assign start      = act && (cmd_q == CMD_RUN);
    assign sweeps     = wdata[SWEEP_W-1:0];
    assign load       = act && (cmd_q == CMD_LOAD_SPINS);
    assign load_spins = wdata[N-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
            cmd_q   <= CMD_WRITE_WEIGHT;
            ack     <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req) begin
                        cmd_q   <= cmd;
                        state_q <= ST_ACT;
                    end
                end
                ST_ACT: begin
                    state_q <= ST_ACK;
                end
                ST_ACK: begin
                    // A run holds here until the engine drops busy
                    if (!busy) begin
                        ack     <= 1'b1;
                        state_q <= ST_RELEASE;
                    end
                end
                default: begin
                    if (!req) begin
                        ack     <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Sign extended weight after a read, current spins after a load or run
    always_ff @(posedge clk) begin
        if (act && cmd_q == CMD_READ_WEIGHT) begin
            rdata <= {{(DATA_W - W){m_rdata[W-1]}}, m_rdata};
        end else if (state_q == ST_ACK && !busy &&
                     (cmd_q == CMD_LOAD_SPINS || cmd_q == CMD_RUN)) begin
            rdata <= {{(DATA_W - N){1'b0}}, spins};
        end
    end

endmodule

`default_nettype wire

//--- verilog/recursive_matrix.sv
// --------------------------------------------------------------------------
// Coupling array that splits into quadrants down to single cells
// Only the upper triangle is built since couplings are symmetric
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module recursive_matrix #(
    parameter int N        = 8,
    parameter int W        = 5,
    parameter int DIAGONAL = 1
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          sel,
    input  wire                          we,
    input  wire  [ising_pkg::ADDR_W-1:0] s_addr,
    input  wire  [ising_pkg::ADDR_W-1:0] d_addr,
    input  wire  [W-1:0]                 wdata,
    output logic [W-1:0]                 rdata
);

    import ising_pkg::*;

    generate
        if (N != 1) begin : g_recurse
            logic              s_hi;
            logic              d_hi;
            logic              tl_sel;
            logic              tr_sel;
            logic              br_sel;
            logic [ADDR_W-1:0] s_next;
            logic [ADDR_W-1:0] d_next;
            logic [W-1:0]      tl_rdata;
            logic [W-1:0]      tr_rdata;
            logic [W-1:0]      bl_rdata;
            logic [W-1:0]      br_rdata;

            // Quadrant is picked by the top bit of each address
            assign s_hi = s_addr[ADDR_W-1];
            assign d_hi = d_addr[ADDR_W-1];

            assign tl_sel = sel & ~s_hi & ~d_hi;
            assign tr_sel = sel & ~s_hi &  d_hi;
            assign br_sel = sel &  s_hi &  d_hi;

            // Next level looks at the following index bit
            assign s_next = {s_addr[ADDR_W-2:0], 1'b0};
            assign d_next = {d_addr[ADDR_W-2:0], 1'b0};

            // Reads follow the address alone
            always_comb begin
                case ({s_hi, d_hi})
                    2'b00:   rdata = tl_rdata;
                    2'b01:   rdata = tr_rdata;
                    2'b10:   rdata = bl_rdata;
                    default: rdata = br_rdata;
                endcase
            end

            recursive_matrix #(.N(N / 2), .W(W), .DIAGONAL(DIAGONAL)) top_left (
                .clk    (clk),
                .reset  (reset),
                .sel    (tl_sel),
                .we     (we),
                .s_addr (s_next),
                .d_addr (d_next),
                .wdata  (wdata),
                .rdata  (tl_rdata)
            );

            // Off the diagonal all the way down
            recursive_matrix #(.N(N / 2), .W(W), .DIAGONAL(0)) top_right (
                .clk    (clk),
                .reset  (reset),
                .sel    (tr_sel),
                .we     (we),
                .s_addr (s_next),
                .d_addr (d_next),
                .wdata  (wdata),
                .rdata  (tr_rdata)
            );

            if (DIAGONAL == 0) begin : g_bot_left
                logic bl_sel;

                // An off-diagonal block holds every pair of its two index ranges
                assign bl_sel = sel & s_hi & ~d_hi;

                recursive_matrix #(.N(N / 2), .W(W), .DIAGONAL(0)) bot_left (
                    .clk    (clk),
                    .reset  (reset),
                    .sel    (bl_sel),
                    .we     (we),
                    .s_addr (s_next),
                    .d_addr (d_next),
                    .wdata  (wdata),
                    .rdata  (bl_rdata)
                );
            end else begin : g_no_bot_left
                // Mirror of the top right on the diagonal
                assign bl_rdata = '0;
            end

            recursive_matrix #(.N(N / 2), .W(W), .DIAGONAL(DIAGONAL)) bot_right (
                .clk    (clk),
                .reset  (reset),
                .sel    (br_sel),
                .we     (we),
                .s_addr (s_next),
                .d_addr (d_next),
                .wdata  (wdata),
                .rdata  (br_rdata)
            );
        end else if (DIAGONAL == 1) begin : g_diag_leaf
            // A spin has no coupling to itself
            assign rdata = '0;
        end else begin : g_weight_leaf
            weight_cell #(.W(W)) u_cell (
                .clk   (clk),
                .reset (reset),
                .sel   (sel),
                .we    (we),
                .wdata (wdata),
                .rdata (rdata)
            );
        end
    endgenerate

endmodule

`default_nettype wire

//--- verilog/weight_cell.sv
// --------------------------------------------------------------------------
// Off-diagonal coupling leaf, holds one signed weight for the matrix
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module weight_cell #(
    parameter int W = 5
) (
    input  wire          clk,
    input  wire          reset,
    input  wire          sel,
    input  wire          we,
    input  wire  [W-1:0] wdata,
    output logic [W-1:0] rdata
);

    // Two's complement coupling weight
    logic [W-1:0] weight_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            weight_q <= '0;
        end else if (sel && we) begin
            weight_q <= wdata;
        end
    end

    // Read is steered by the parent levels
    assign rdata = weight_q;

endmodule

`default_nettype wire

//--- verilog/ising_pkg.sv
// --------------------------------------------------------------------------
// Widths and host command codes shared by the annealer RTL and testbench
// --------------------------------------------------------------------------
`default_nettype none

package ising_pkg;

    // Matrix address width, the index sits in the top bits
    localparam int ADDR_W = 16;

    // Host write data and read data width
    localparam int DATA_W = 32;

    // Sweep count taken from the low bits of the host data
    localparam int SWEEP_W = 16;

    // Host commands
    typedef enum logic [1:0] {
        // Store a weight at (row, col)
        CMD_WRITE_WEIGHT = 2'd0,
        // Return the weight at (row, col)
        CMD_READ_WEIGHT  = 2'd1,
        // Low N bits of the data become the spins
        CMD_LOAD_SPINS   = 2'd2,
        // Run the number of sweeps in the low data bits
        CMD_RUN          = 2'd3
    } cmd_e;

endpackage

`default_nettype wire
